/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f noc_sched.f --top-module tb_noc_sched \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* flit_fifo.sv */
module flit_fifo (
     input  logic                                      clk
    ,input  logic                                      rst

    ,input  logic                                      wr_val
    ,input  logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  wr_data
    ,output logic                                      wr_rdy

    ,output logic                                      rd_val
    ,output logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  rd_data
    ,input  logic                                      rd_rdy
);

    import noc_sched_pkg::*;

    logic [NOC_DATA_WIDTH-1:0] mem [4];
    logic [1:0]                wr_ptr;
    logic [1:0]                rd_ptr;
    logic [2:0]                count;
    logic                      full;
    logic                      do_wr;
    logic                      do_rd;

    assign full   = count == 3'd4;
    assign rd_val = count != 3'd0;
    assign wr_rdy = ~full | rd_rdy; // A read frees a slot this cycle.

    assign do_wr = wr_val & wr_rdy;
    assign do_rd = rd_val & rd_rdy;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at four by width.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* noc_sched.f */
+incdir+.
noc_sched_pkg.sv
sched_table.sv
rr_scheduler.sv
flit_fifo.sv
noc_sched_top.sv
tb_noc_sched.sv

/* noc_sched_pkg.sv */
package noc_sched_pkg;

    localparam int NOC_DATA_WIDTH = 64;
    localparam int XY_WIDTH       = 8;
    localparam int MSG_LEN_WIDTH  = 8;

    // Destination table size.
    localparam int NUM_DSTS   = 4;
    localparam int NUM_DSTS_W = 2;

    // Header flit layout, top bit first.
    typedef struct packed {
        logic [XY_WIDTH-1:0]      dst_x;
        logic [XY_WIDTH-1:0]      dst_y;
        logic [XY_WIDTH-1:0]      src_x;
        logic [XY_WIDTH-1:0]      src_y;
        logic [MSG_LEN_WIDTH-1:0] msg_len; // Body flits that follow.
        logic [NOC_DATA_WIDTH-4*XY_WIDTH-MSG_LEN_WIDTH-1:0] meta;
    } noc_hdr_flit;

    // One destination. Sits in bits 15:0 of a Wishbone word.
    typedef struct packed {
        logic [XY_WIDTH-1:0] dst_x;
        logic [XY_WIDTH-1:0] dst_y;
    } sched_table_entry;

    typedef enum logic [0:0] {
        READY     = 1'b0, // Waiting for a header.
        PASS_BODY = 1'b1
    } sched_state_e;

endpackage

/* noc_sched_top.sv */
module noc_sched_top (
     input  logic                                      clk
    ,input  logic                                      rst

    // Flit input.
    ,input  logic                                      in_val
    ,input  logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  in_data
    ,output logic                                      in_rdy

    // Flit output.
    ,output logic                                      out_val
    ,output logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  out_data
    ,input  logic                                      out_rdy

    // Host table access.
    ,input  logic                                      wb_cyc
    ,input  logic                                      wb_stb
    ,input  logic                                      wb_we
    ,input  logic [noc_sched_pkg::NUM_DSTS_W-1:0]      wb_adr
    ,input  logic [31:0]                               wb_dat_w
    ,output logic [31:0]                               wb_dat_r
    ,output logic                                      wb_ack
);

    import noc_sched_pkg::*;

    logic                      sched_val;
    logic [NOC_DATA_WIDTH-1:0] sched_data;
    logic                      fifo_rdy;

    logic [NUM_DSTS_W-1:0]     read_index;
    sched_table_entry          read_entry;

    sched_table i_sched_table (
         .clk        (clk)
        ,.rst        (rst)
        ,.wb_cyc     (wb_cyc)
        ,.wb_stb     (wb_stb)
        ,.wb_we      (wb_we)
        ,.wb_adr     (wb_adr)
        ,.wb_dat_w   (wb_dat_w)
        ,.wb_dat_r   (wb_dat_r)
        ,.wb_ack     (wb_ack)
        ,.read_index (read_index)
        ,.read_entry (read_entry)
    );

    rr_scheduler i_rr_scheduler (
         .clk        (clk)
        ,.rst        (rst)
        ,.in_val     (in_val)
        ,.in_data    (in_data)
        ,.in_rdy     (in_rdy)
        ,.sched_val  (sched_val)
        ,.sched_data (sched_data)
        ,.fifo_rdy   (fifo_rdy)
        ,.read_index (read_index)
        ,.read_entry (read_entry)
    );

    // Decouples the scheduler from downstream stalls.
    flit_fifo i_flit_fifo (
         .clk     (clk)
        ,.rst     (rst)
        ,.wr_val  (sched_val)
        ,.wr_data (sched_data)
        ,.wr_rdy  (fifo_rdy)
        ,.rd_val  (out_val)
        ,.rd_data (out_data)
        ,.rd_rdy  (out_rdy)
    );

endmodule

/* rr_scheduler.sv */
module rr_scheduler (
     input  logic                                      clk
    ,input  logic                                      rst

    ,input  logic                                      in_val
    ,input  logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  in_data
    ,output logic                                      in_rdy

    ,output logic                                      sched_val
    ,output logic [noc_sched_pkg::NOC_DATA_WIDTH-1:0]  sched_data
    ,input  logic                                      fifo_rdy

    ,output logic [noc_sched_pkg::NUM_DSTS_W-1:0]      read_index
    ,input  noc_sched_pkg::sched_table_entry           read_entry
);

    import noc_sched_pkg::*;

    sched_state_e state_reg;
    sched_state_e state_next;

    logic [NUM_DSTS_W-1:0]    index_reg;
    logic [NUM_DSTS_W-1:0]    index_next;
    logic                     incr_index;

    logic [MSG_LEN_WIDTH-1:0] len_reg;
    logic [MSG_LEN_WIDTH-1:0] body_cnt_reg;
    logic                     store_len;
    logic                     incr_body_cnt;
    logic                     last_body;

    logic                     xfer;
    noc_hdr_flit              hdr_in;
    noc_hdr_flit              hdr_out;

    assign hdr_in = in_data;
    assign xfer   = in_val & fifo_rdy;

    // Pure pass-through handshake in both states.
    assign in_rdy    = fifo_rdy;
    assign sched_val = in_val;

    assign sched_data = (state_reg == READY) ? hdr_out : in_data;

    assign last_body = body_cnt_reg == (len_reg - 1'b1);

    // Table sees the next index so read_entry matches index_reg.
    assign read_index = index_next;

    assign index_next = incr_index
                      ? ((index_reg == NUM_DSTS_W'(NUM_DSTS - 1)) ? '0 : index_reg + 1'b1)
                      : index_reg;

    always_comb begin
        hdr_out       = hdr_in;
        hdr_out.dst_x = read_entry.dst_x;
        hdr_out.dst_y = read_entry.dst_y;
    end

    always_comb begin
        state_next    = state_reg;
        incr_index    = 1'b0;
        store_len     = 1'b0;
        incr_body_cnt = 1'b0;

        case (state_reg)
            READY: begin
                if (xfer) begin
                    store_len = 1'b1;
                    if (hdr_in.msg_len == '0) begin
                        incr_index = 1'b1; // Header-only message.
                    end
                    else begin
                        state_next = PASS_BODY;
                    end
                end
            end
            PASS_BODY: begin
                if (xfer) begin
                    incr_body_cnt = 1'b1;
                    if (last_body) begin
                        incr_index = 1'b1;
                        state_next = READY;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
            index_reg <= '0;
        end
        else begin
            state_reg <= state_next;
            index_reg <= index_next;
        end
    end

    // Message length and body position.
    always_ff @(posedge clk) begin
        if (rst) begin
            len_reg      <= '0;
            body_cnt_reg <= '0;
        end
        else if (store_len) begin
            len_reg      <= hdr_in.msg_len;
            body_cnt_reg <= '0;
        end
        else if (incr_body_cnt) begin
            body_cnt_reg <= body_cnt_reg + 1'b1;
        end
    end

endmodule

/* sched_table.sv */
module sched_table (
     input  logic                                  clk
    ,input  logic                                  rst

    // Wishbone classic slave.
    ,input  logic                                  wb_cyc
    ,input  logic                                  wb_stb
    ,input  logic                                  wb_we
    ,input  logic [noc_sched_pkg::NUM_DSTS_W-1:0]  wb_adr
    ,input  logic [31:0]                           wb_dat_w
    ,output logic [31:0]                           wb_dat_r
    ,output logic                                  wb_ack

    // Scheduler read port.
    ,input  logic [noc_sched_pkg::NUM_DSTS_W-1:0]  read_index
    ,output noc_sched_pkg::sched_table_entry       read_entry
);

    import noc_sched_pkg::*;

    sched_table_entry entries [NUM_DSTS];
    sched_table_entry rd_word;
    logic             wb_req;

    // New request only while no ack is pending.
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    assign wb_dat_r = {{(32-$bits(sched_table_entry)){1'b0}}, rd_word};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end
        else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_DSTS; i++) begin
                entries[i] <= '0;
            end
        end
        else if (wb_req & wb_we) begin
            entries[wb_adr] <= wb_dat_w[$bits(sched_table_entry)-1:0];
        end
    end

    // Host read data, held through the ack cycle.
    always_ff @(posedge clk) begin
        if (wb_req & ~wb_we) begin
            rd_word <= entries[wb_adr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_entry <= '0;
        end
        else begin
            read_entry <= entries[read_index]; // Follows read_index by one cycle.
        end
    end

endmodule

/* tb_noc_sched_model.svh */
`ifndef TB_NOC_SCHED_MODEL_SVH
`define TB_NOC_SCHED_MODEL_SVH

// Copy of the destination table, dst_x in 15:8 and dst_y in 7:0.
logic [15:0]               table_mirror [NUM_DSTS];
logic [NUM_DSTS_W-1:0]     model_index;
logic [MSG_LEN_WIDTH-1:0]  body_left;    // Body flits still owed.
logic                      in_body;
logic [NOC_DATA_WIDTH-1:0] exp_q [$];

function automatic void clear_model();
    for (int i = 0; i < NUM_DSTS; i++) begin
        table_mirror[NUM_DSTS_W'(i)] = '0;
    end
    model_index = '0;
    body_left   = '0;
    in_body     = 1'b0;
    exp_q.delete();
endfunction

function automatic void record_write(logic [NUM_DSTS_W-1:0] adr, logic [31:0] data);
    table_mirror[adr] = data[15:0];
endfunction

// Round-robin step, wraps after the last entry.
function automatic void advance_index();
    if (model_index == NUM_DSTS_W'(NUM_DSTS - 1)) begin
        model_index = '0;
    end
    else begin
        model_index = model_index + 1'b1;
    end
endfunction

function automatic void frame_input(logic [NOC_DATA_WIDTH-1:0] flit);
    logic [NOC_DATA_WIDTH-1:0] exp_flit;
    exp_flit = flit;
    if (!in_body) begin
        exp_flit[63:48] = table_mirror[model_index]; // New dst_x and dst_y.
        body_left = flit[31:24];
        if (flit[31:24] == '0) begin
            advance_index(); // Header-only message.
        end
        else begin
            in_body = 1'b1;
        end
    end
    else begin
        body_left = body_left - 1'b1;
        if (body_left == '0) begin
            in_body = 1'b0;
            advance_index();
        end
    end
    exp_q.push_back(exp_flit);
endfunction

`endif

/* tb_noc_sched.sv */
module tb_noc_sched;

    import noc_sched_pkg::*;

    localparam int SEED           = 58587;
    localparam int RESET_CYCLES   = 3;
    localparam int NUM_BURSTS     = 4;
    localparam int MSGS_PER_BURST = 50;
    localparam int MAX_LEN        = 6;
    localparam int TIMEOUT_CYCLES = 20000; // About 1000 flits at half rate, wide margin.

    logic                      clk;
    logic                      rst;
    logic                      in_val;
    logic [NOC_DATA_WIDTH-1:0] in_data;
    logic                      in_rdy;
    logic                      out_val;
    logic [NOC_DATA_WIDTH-1:0] out_data;
    logic                      out_rdy;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [NUM_DSTS_W-1:0]     wb_adr;
    logic [31:0]               wb_dat_w;
    logic [31:0]               wb_dat_r;
    logic                      wb_ack;
    int                        cycle_cnt = 0;

    `include "tb_noc_sched_model.svh"

    noc_sched_top i_noc_sched_top (
         .clk      (clk)
        ,.rst      (rst)
        ,.in_val   (in_val)
        ,.in_data  (in_data)
        ,.in_rdy   (in_rdy)
        ,.out_val  (out_val)
        ,.out_data (out_data)
        ,.out_rdy  (out_rdy)
        ,.wb_cyc   (wb_cyc)
        ,.wb_stb   (wb_stb)
        ,.wb_we    (wb_we)
        ,.wb_adr   (wb_adr)
        ,.wb_dat_w (wb_dat_w)
        ,.wb_dat_r (wb_dat_r)
        ,.wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Downstream stalls about 40% of cycles.
    initial begin
        out_rdy = 1'b0;
        forever begin
            @(negedge clk);
            out_rdy = ($urandom % 10) >= 4;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // Model update and output compare at every handshake.
    always @(posedge clk) begin
        logic [NOC_DATA_WIDTH-1:0] exp_flit;
        if (rst) begin
            clear_model();
        end
        else begin
            if (wb_cyc && wb_stb && wb_we && !wb_ack) begin
                record_write(wb_adr, wb_dat_w);
            end
            if (out_val && out_rdy) begin
                assert (exp_q.size() != 0)
                    else fail_run("output flit appeared with no flit expected by the model");
                exp_flit = exp_q.pop_front();
                assert (out_data === exp_flit)
                    else fail_run($sformatf("mismatch out_data: expected %h got %h",
                                            exp_flit, out_data));
            end
            if (in_val && in_rdy) begin
                frame_input(in_data);
            end
        end
    end

    task automatic bus_access(input logic we, input logic [NUM_DSTS_W-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        assert (wb_ack === 1'b0)
            else fail_run($sformatf("mismatch wb_ack: expected 0 got %h", wb_ack));
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        assert (wb_ack === 1'b1)
            else fail_run($sformatf("mismatch wb_ack: expected 1 got %h", wb_ack));
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        assert (wb_ack === 1'b0) // Ack lasts a single cycle.
            else fail_run($sformatf("mismatch wb_ack: expected 0 got %h", wb_ack));
    endtask

    task automatic check_readback();
        logic [NUM_DSTS_W-1:0] adr;
        logic [31:0]           rdata;
        logic [31:0]           exp_word;
        for (int i = 0; i < NUM_DSTS; i++) begin
            adr = NUM_DSTS_W'(i);
            bus_access(1'b0, adr, 32'h0, rdata);
            exp_word = {16'h0, table_mirror[adr]};
            assert (rdata === exp_word)
                else fail_run($sformatf("mismatch wb_dat_r[%0d]: expected %h got %h",
                                        i, exp_word, rdata));
        end
    endtask

    task automatic program_table();
        logic [31:0] rdata;
        for (int i = 0; i < NUM_DSTS; i++) begin
            bus_access(1'b1, NUM_DSTS_W'(i), $urandom, rdata);
        end
        check_readback();
    endtask

    task automatic apply_reset();
        rst    = 1'b1;
        in_val = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_reset_state();
        assert (out_val === 1'b0)
            else fail_run($sformatf("mismatch out_val: expected 0 got %h", out_val));
        assert (wb_ack === 1'b0)
            else fail_run($sformatf("mismatch wb_ack: expected 0 got %h", wb_ack));
        assert (in_rdy === 1'b1)
            else fail_run($sformatf("mismatch in_rdy: expected 1 got %h", in_rdy));
        check_readback(); // All entries read zero.
    endtask

    // Holds valid and data until the handshake.
    task automatic send_flit(input logic [NOC_DATA_WIDTH-1:0] flit);
        int unsigned gap;
        gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
        in_val = 1'b0;
        repeat (gap) @(negedge clk);
        in_val  = 1'b1;
        in_data = flit;
        do begin
            @(posedge clk);
        end while (!in_rdy);
        @(negedge clk);
        in_val = 1'b0;
    endtask

    task automatic send_message();
        logic [NOC_DATA_WIDTH-1:0] hdr;
        logic [MSG_LEN_WIDTH-1:0]  len;
        len = ($urandom % 8 == 0) ? '0 : MSG_LEN_WIDTH'(1 + $urandom % MAX_LEN);
        hdr = {$urandom, $urandom};
        hdr[31:24] = len;
        send_flit(hdr);
        for (int i = 0; i < int'(len); i++) begin
            send_flit({$urandom, $urandom});
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (out_val === 1'b0)
            else fail_run($sformatf("mismatch out_val: expected 0 got %h", out_val));
    endtask

    initial begin
        rst      = 1'b1;
        in_val   = 1'b0;
        in_data  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(SEED));
        apply_reset();
        check_reset_state();
        for (int b = 0; b < NUM_BURSTS; b++) begin
            if (b == 1) begin
                apply_reset(); // Index must restart at entry 0.
                check_reset_state();
            end
            program_table();
            for (int m = 0; m < MSGS_PER_BURST; m++) begin
                send_message();
            end
            wait_drain();
        end
        $display("Test OK");
        $finish;
    end

endmodule
